//--- rtl/lcc_trans_params.svh
/*
  Shared widths for the lifecycle state translator
  Lifecycle code, unlock level and mask widths
  Zeroization mask width
  Multibit lifecycle enable width and its On code
*/

`ifndef LCC_TRANS_PARAMS_SVH
`define LCC_TRANS_PARAMS_SVH

// ----------------------------------------
// Lifecycle code
// ----------------------------------------

// Compact lifecycle code from the OTP and the lifecycle controller
// Codes 21 to 31 are not assigned
`define LCC_STATE_W 5

// ----------------------------------------
// SoC debug policy
// ----------------------------------------

// Debug unlock level and the DFT, debug and CLTAP masks
`define UNLOCK_W 64

// MCU ROM zeroization mask
`define ZEROIZE_MASK_W 32

// ----------------------------------------
// Multibit lifecycle enables
// ----------------------------------------

// Only the exact On pattern enables
// Every other value is off
`define LC_TX_W 4
`define LC_TX_ON 4'b0101

`endif

//--- rtl/lcc_trans_pkg.sv
/*
  Types for the lifecycle state translator
  Lifecycle code enum
  Translator FSM state enum
  Core device lifecycle class enum
*/

`include "lcc_trans_params.svh"

package lcc_trans_pkg;

  // Lifecycle code as held in OTP
  typedef enum logic [`LCC_STATE_W-1:0] {
    LC_RAW             = 5'd0,
    LC_TEST_UNLOCKED0  = 5'd1,
    LC_TEST_UNLOCKED1  = 5'd2,
    LC_TEST_UNLOCKED2  = 5'd3,
    LC_TEST_UNLOCKED3  = 5'd4,
    LC_TEST_UNLOCKED4  = 5'd5,
    LC_TEST_UNLOCKED5  = 5'd6,
    LC_TEST_UNLOCKED6  = 5'd7,
    LC_TEST_UNLOCKED7  = 5'd8,
    LC_TEST_LOCKED0    = 5'd9,
    LC_TEST_LOCKED1    = 5'd10,
    LC_TEST_LOCKED2    = 5'd11,
    LC_TEST_LOCKED3    = 5'd12,
    LC_TEST_LOCKED4    = 5'd13,
    LC_TEST_LOCKED5    = 5'd14,
    LC_TEST_LOCKED6    = 5'd15,
    LC_DEV             = 5'd16,
    LC_PROD            = 5'd17,
    LC_PROD_END        = 5'd18,
    LC_RMA             = 5'd19,
    LC_SCRAP           = 5'd20
  } lc_state_e;

  // Translator FSM states
  typedef enum logic [2:0] {
    TRANS_RESET           = 3'd0,
    TRANS_IDLE            = 3'd1,
    TRANS_NON_DEBUG       = 3'd2,
    TRANS_UNPROV_DEBUG    = 3'd3,
    TRANS_MANUF_NON_DEBUG = 3'd4,
    TRANS_MANUF_DEBUG     = 3'd5,
    TRANS_PROD_NON_DEBUG  = 3'd6,
    TRANS_PROD_DEBUG      = 3'd7
  } trans_state_e;

  // Core security lifecycle class
  typedef enum logic [1:0] {
    DEVICE_UNPROVISIONED = 2'b00,
    DEVICE_MANUFACTURING = 2'b01,
    DEVICE_PRODUCTION    = 2'b11
  } device_lifecycle_e;

endpackage

//--- rtl/soc_unlock_policy.sv
/*
  SoC unlock policy
  Masked matches of the debug unlock level
  SCRAP request detection from the lifecycle program request
  Registered zeroization command
*/

`timescale 1ns/100ps

`include "lcc_trans_params.svh"

module soc_unlock_policy (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Debug unlock level and SoC masks
  input  logic [`UNLOCK_W-1:0]          unlock_level_i,
  input  logic [`UNLOCK_W-1:0]          dft_en_mask_i,
  input  logic [`UNLOCK_W-1:0]          dbg_unlock_mask_i,
  input  logic [`UNLOCK_W-1:0]          cltap_unlock_mask_i,

  // Lifecycle controller program request
  input  logic                          lc_prog_req_i,
  input  lcc_trans_pkg::lc_state_e      lc_alive_state_i,

  // Zeroization controls
  input  logic [`ZEROIZE_MASK_W-1:0]    zeroize_mask_i,
  input  logic                          zeroize_ppd_i,

  output logic                          dft_hit_o,
  output logic                          hw_dbg_hit_o,
  output logic                          prod_unlock_hit_o,
  output logic                          scrap_req_o,
  output logic                          zeroize_cmd_o
);

  import lcc_trans_pkg::*;

  logic zeroize_d;

  // ----------------------------------------
  // Unlock level matches
  // ----------------------------------------

  // Any unlock level bit that the mask also sets is a hit
  assign dft_hit_o         = |(unlock_level_i & dft_en_mask_i);
  assign hw_dbg_hit_o      = |(unlock_level_i & cltap_unlock_mask_i);
  // Production debug unlock feeds the FSM
  assign prod_unlock_hit_o = |(unlock_level_i & dbg_unlock_mask_i);

  // Lifecycle controller asks OTP to program SCRAP
  assign scrap_req_o = lc_prog_req_i && (lc_alive_state_i == LC_SCRAP);

  // ----------------------------------------
  // Zeroization
  // ----------------------------------------

  // Full mask plus power-on permit
  assign zeroize_d = (&zeroize_mask_i) & zeroize_ppd_i;

  // Registered without the OTP valid qualifier
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      zeroize_cmd_o <= 1'b0;
    end else begin
      zeroize_cmd_o <= zeroize_d;
    end
  end

endmodule

//--- rtl/sec_state_fsm.sv
/*
  Security state translator FSM
  Latches the OTP lifecycle code while OTP data is valid
  Maps the code to a core lifecycle class and debug lock
  Applies the kill, manufacturing and production unlock transitions
  Registered security state output
*/

`timescale 1ns/100ps

`include "lcc_trans_params.svh"

module sec_state_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // OTP handshake and static state
  input  logic                              otp_valid_i,
  input  lcc_trans_pkg::lc_state_e          otp_state_i,

  // Kill sources
  input  logic                              scrap_req_i,
  input  logic                              state_error_i,

  // Debug unlock sources
  input  logic                              manuf_dbg_en_i,
  input  logic                              prod_unlock_hit_i,

  output lcc_trans_pkg::device_lifecycle_e  device_lifecycle_o,
  output logic                              debug_locked_o
);

  import lcc_trans_pkg::*;

  trans_state_e      state_q;
  trans_state_e      state_d;
  lc_state_e         otp_state_q;
  device_lifecycle_e lifecycle_d;
  logic              locked_d;

  logic              kill;
  logic              st_test_locked;
  logic              st_test_unlocked;
  logic              st_prod;

  // SCRAP request or state error forces non-debug
  assign kill = scrap_req_i || state_error_i;

  // ----------------------------------------
  // Latched code classification
  // ----------------------------------------

  // RAW counts with the locked test states
  assign st_test_locked = (otp_state_q == LC_RAW) ||
                          (otp_state_q inside {[LC_TEST_LOCKED0 : LC_TEST_LOCKED6]});

  assign st_test_unlocked = otp_state_q inside {[LC_TEST_UNLOCKED0 : LC_TEST_UNLOCKED7]};

  // PROD and PROD_END share one translator state
  assign st_prod = (otp_state_q == LC_PROD) || (otp_state_q == LC_PROD_END);

  // ----------------------------------------
  // Next state and output decode
  // ----------------------------------------

  always_comb begin
    // Safe output unless a state says otherwise
    state_d     = state_q;
    lifecycle_d = DEVICE_PRODUCTION;
    locked_d    = 1'b1;

    case (state_q)
      TRANS_RESET: begin
        state_d = TRANS_IDLE;
      end

      TRANS_IDLE: begin
        // Kill first, then the latched lifecycle class
        if (kill || (otp_state_q == LC_SCRAP)) begin
          state_d = TRANS_NON_DEBUG;
        end else if (st_test_locked) begin
          state_d = TRANS_NON_DEBUG;
        end else if (st_test_unlocked) begin
          state_d = TRANS_UNPROV_DEBUG;
        end else if (otp_state_q == LC_DEV) begin
          state_d = TRANS_MANUF_NON_DEBUG;
        end else if (st_prod) begin
          state_d = TRANS_PROD_NON_DEBUG;
        end else if (otp_state_q == LC_RMA) begin
          state_d = TRANS_PROD_DEBUG;
        end else begin
          // Unassigned code waits here
          state_d = TRANS_IDLE;
        end
      end

      // Absorbing until OTP valid drops
      TRANS_NON_DEBUG: begin
        state_d = TRANS_NON_DEBUG;
      end

      TRANS_UNPROV_DEBUG: begin
        if (kill) begin
          state_d = TRANS_NON_DEBUG;
        end else begin
          lifecycle_d = DEVICE_UNPROVISIONED;
          locked_d    = 1'b0;
        end
      end

      TRANS_MANUF_NON_DEBUG: begin
        if (kill) begin
          state_d = TRANS_NON_DEBUG;
        end else begin
          lifecycle_d = DEVICE_MANUFACTURING;
          // Unlock shows once the debug state is reached
          if (manuf_dbg_en_i) begin
            state_d = TRANS_MANUF_DEBUG;
          end
        end
      end

      TRANS_MANUF_DEBUG: begin
        if (kill) begin
          state_d = TRANS_NON_DEBUG;
        end else begin
          lifecycle_d = DEVICE_MANUFACTURING;
          locked_d    = 1'b0;
        end
      end

      TRANS_PROD_NON_DEBUG: begin
        if (kill) begin
          state_d = TRANS_NON_DEBUG;
        end else if (prod_unlock_hit_i) begin
          state_d = TRANS_PROD_DEBUG;
        end
      end

      TRANS_PROD_DEBUG: begin
        if (kill) begin
          state_d = TRANS_NON_DEBUG;
        end else begin
          locked_d = 1'b0;
        end
      end

      default: begin
        state_d = TRANS_IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // State and output registers
  // ----------------------------------------

  // Invalid OTP data returns everything to the safe defaults
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= TRANS_RESET;
      otp_state_q        <= LC_RAW;
      device_lifecycle_o <= DEVICE_PRODUCTION;
      debug_locked_o     <= 1'b1;
    end else if (otp_valid_i) begin
      state_q            <= state_d;
      otp_state_q        <= otp_state_i;
      device_lifecycle_o <= lifecycle_d;
      debug_locked_o     <= locked_d;
    end else begin
      state_q            <= TRANS_RESET;
      otp_state_q        <= LC_RAW;
      device_lifecycle_o <= DEVICE_PRODUCTION;
      debug_locked_o     <= 1'b1;
    end
  end

endmodule

//--- rtl/debug_enable_gate.sv
/*
  SoC debug enable gate
  Strict decode of the multibit DFT and hardware debug enables
  Merge with the SoC mask hits and SCRAP suppression
  Registered under the OTP valid qualifier
*/

`timescale 1ns/100ps

`include "lcc_trans_params.svh"

module debug_enable_gate (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  otp_valid_i,

  // Multibit enables from the lifecycle controller
  input  logic [`LC_TX_W-1:0]   lc_dft_en_i,
  input  logic [`LC_TX_W-1:0]   lc_hw_debug_en_i,

  // Policy results
  input  logic                  dft_hit_i,
  input  logic                  hw_dbg_hit_i,
  input  logic                  scrap_req_i,

  output logic                  soc_dft_en_o,
  output logic                  soc_hw_debug_en_o
);

  logic dft_en_d;
  logic hw_debug_en_d;

  // Only the exact On pattern counts
  // SCRAP overrides both enables
  assign dft_en_d      = ((lc_dft_en_i == `LC_TX_ON) || dft_hit_i) && !scrap_req_i;
  assign hw_debug_en_d = ((lc_hw_debug_en_i == `LC_TX_ON) || hw_dbg_hit_i) && !scrap_req_i;

  // ----------------------------------------
  // Output registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end else if (otp_valid_i) begin
      soc_dft_en_o      <= dft_en_d;
      soc_hw_debug_en_o <= hw_debug_en_d;
    end else begin
      // Both off while OTP data is not valid
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end
  end

endmodule

//--- rtl/lcc_st_trans_top.sv
/*
  Lifecycle state translator top level
  SoC unlock policy, translator FSM and debug enable gate
  Produces the core security state, SoC debug enables
  and the zeroization command
*/

`timescale 1ns/100ps

`include "lcc_trans_params.svh"

module lcc_st_trans_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // OTP static state and valid qualifier
  input  logic                              otp_valid_i,
  input  lcc_trans_pkg::lc_state_e          otp_state_i,

  // Lifecycle controller
  input  logic                              lc_prog_req_i,
  input  lcc_trans_pkg::lc_state_e          lc_alive_state_i,
  input  logic [`LC_TX_W-1:0]               lc_dft_en_i,
  input  logic [`LC_TX_W-1:0]               lc_hw_debug_en_i,

  // Core and SoC controls
  input  logic                              state_error_i,
  input  logic                              manuf_dbg_en_i,
  input  logic [`UNLOCK_W-1:0]              unlock_level_i,
  input  logic [`UNLOCK_W-1:0]              dft_en_mask_i,
  input  logic [`UNLOCK_W-1:0]              dbg_unlock_mask_i,
  input  logic [`UNLOCK_W-1:0]              cltap_unlock_mask_i,

  // Zeroization
  input  logic [`ZEROIZE_MASK_W-1:0]        zeroize_mask_i,
  input  logic                              zeroize_ppd_i,
  output logic                              zeroize_cmd_o,

  // SoC debug enables
  output logic                              soc_dft_en_o,
  output logic                              soc_hw_debug_en_o,

  // Core security state
  output lcc_trans_pkg::device_lifecycle_e  device_lifecycle_o,
  output logic                              debug_locked_o
);

  // Policy results
  logic scrap_req;
  logic prod_unlock_hit;
  logic dft_hit;
  logic hw_dbg_hit;

  // ----------------------------------------
  // Unlock policy
  // ----------------------------------------

  soc_unlock_policy u_soc_unlock_policy (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .unlock_level_i      (unlock_level_i),
    .dft_en_mask_i       (dft_en_mask_i),
    .dbg_unlock_mask_i   (dbg_unlock_mask_i),
    .cltap_unlock_mask_i (cltap_unlock_mask_i),
    .lc_prog_req_i       (lc_prog_req_i),
    .lc_alive_state_i    (lc_alive_state_i),
    .zeroize_mask_i      (zeroize_mask_i),
    .zeroize_ppd_i       (zeroize_ppd_i),
    .dft_hit_o           (dft_hit),
    .hw_dbg_hit_o        (hw_dbg_hit),
    .prod_unlock_hit_o   (prod_unlock_hit),
    .scrap_req_o         (scrap_req),
    .zeroize_cmd_o       (zeroize_cmd_o)
  );

  // Translator FSM
  sec_state_fsm u_sec_state_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .otp_valid_i        (otp_valid_i),
    .otp_state_i        (otp_state_i),
    .scrap_req_i        (scrap_req),
    .state_error_i      (state_error_i),
    .manuf_dbg_en_i     (manuf_dbg_en_i),
    .prod_unlock_hit_i  (prod_unlock_hit),
    .device_lifecycle_o (device_lifecycle_o),
    .debug_locked_o     (debug_locked_o)
  );

  // SoC enable gating
  debug_enable_gate u_debug_enable_gate (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .otp_valid_i       (otp_valid_i),
    .lc_dft_en_i       (lc_dft_en_i),
    .lc_hw_debug_en_i  (lc_hw_debug_en_i),
    .dft_hit_i         (dft_hit),
    .hw_dbg_hit_i      (hw_dbg_hit),
    .scrap_req_i       (scrap_req),
    .soc_dft_en_o      (soc_dft_en_o),
    .soc_hw_debug_en_o (soc_hw_debug_en_o)
  );

endmodule

//--- test/tb_lcc_st_trans.sv
/*
  Testbench for the lifecycle state translator
  Clock, reset and seeded random stimulus in phases
  Cycle model of the translator, enable gate and zeroization
  Compare tasks and watchdog
*/

`timescale 1ns/100ps

`include "lcc_trans_params.svh"

module tb_lcc_st_trans;

  import lcc_trans_pkg::*;

  // Phase lengths in clock cycles
  // Two invalid cycles open each run
  localparam int INVALID_CYC = 42;
  localparam int CLASS_CYC   = 32 * 10;
  localparam int UNLOCK_CYC  = 3 * 62;
  localparam int KILL_CYC    = 10 * 22;
  localparam int MIXED_CYC   = 4 * 52;
  localparam int TOTAL_CYC   = 4 + INVALID_CYC + CLASS_CYC + UNLOCK_CYC + KILL_CYC + MIXED_CYC;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     otp_valid_i;
  lc_state_e                otp_state_i;
  logic                     lc_prog_req_i;
  lc_state_e                lc_alive_state_i;
  logic [`LC_TX_W-1:0]      lc_dft_en_i;
  logic [`LC_TX_W-1:0]      lc_hw_debug_en_i;
  logic                     state_error_i;
  logic                     manuf_dbg_en_i;
  logic [`UNLOCK_W-1:0]     unlock_level_i;
  logic [`UNLOCK_W-1:0]     dft_en_mask_i;
  logic [`UNLOCK_W-1:0]     dbg_unlock_mask_i;
  logic [`UNLOCK_W-1:0]     cltap_unlock_mask_i;
  logic [`ZEROIZE_MASK_W-1:0] zeroize_mask_i;
  logic                     zeroize_ppd_i;
  logic                     zeroize_cmd_o;
  logic                     soc_dft_en_o;
  logic                     soc_hw_debug_en_o;
  device_lifecycle_e        device_lifecycle_o;
  logic                     debug_locked_o;

  integer seed = 32'h8484;

  // Model state
  trans_state_e      m_state = TRANS_RESET;
  trans_state_e      m_next;
  lc_state_e         m_otp = LC_RAW;
  device_lifecycle_e m_lc = DEVICE_PRODUCTION;
  logic              m_locked = 1'b1;
  logic              m_dft = 1'b0;
  logic              m_hw = 1'b0;
  logic              m_zero = 1'b0;
  logic              m_scrap;
  logic              m_kill;

  lcc_st_trans_top u_lcc_st_trans_top (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .otp_valid_i         (otp_valid_i),
    .otp_state_i         (otp_state_i),
    .lc_prog_req_i       (lc_prog_req_i),
    .lc_alive_state_i    (lc_alive_state_i),
    .lc_dft_en_i         (lc_dft_en_i),
    .lc_hw_debug_en_i    (lc_hw_debug_en_i),
    .state_error_i       (state_error_i),
    .manuf_dbg_en_i      (manuf_dbg_en_i),
    .unlock_level_i      (unlock_level_i),
    .dft_en_mask_i       (dft_en_mask_i),
    .dbg_unlock_mask_i   (dbg_unlock_mask_i),
    .cltap_unlock_mask_i (cltap_unlock_mask_i),
    .zeroize_mask_i      (zeroize_mask_i),
    .zeroize_ppd_i       (zeroize_ppd_i),
    .zeroize_cmd_o       (zeroize_cmd_o),
    .soc_dft_en_o        (soc_dft_en_o),
    .soc_hw_debug_en_o   (soc_hw_debug_en_o),
    .device_lifecycle_o  (device_lifecycle_o),
    .debug_locked_o      (debug_locked_o)
  );

  always #10 clk_i = ~clk_i;

  // ----------------------------------------
  // Random helpers
  // ----------------------------------------

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  // True with the given chance in percent
  function automatic logic roll(input int pct);
    logic [31:0] r;
    r = rand_word();
    return (r % 100) < pct;
  endfunction

  // Translator state reached from IDLE for a lifecycle code
  function automatic trans_state_e class_state(input int code);
    if (code == 0 || (code >= 9 && code <= 15) || code == 20) begin
      return TRANS_NON_DEBUG;
    end else if (code >= 1 && code <= 8) begin
      return TRANS_UNPROV_DEBUG;
    end else if (code == 16) begin
      return TRANS_MANUF_NON_DEBUG;
    end else if (code == 17 || code == 18) begin
      return TRANS_PROD_NON_DEBUG;
    end else if (code == 19) begin
      return TRANS_PROD_DEBUG;
    end
    return TRANS_IDLE;
  endfunction

  // ----------------------------------------
  // Cycle model
  // ----------------------------------------

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_state  = TRANS_RESET;
      m_otp    = LC_RAW;
      m_lc     = DEVICE_PRODUCTION;
      m_locked = 1'b1;
      m_dft    = 1'b0;
      m_hw     = 1'b0;
      m_zero   = 1'b0;
    end else begin
      m_scrap = lc_prog_req_i && (lc_alive_state_i == LC_SCRAP);
      m_kill  = m_scrap || state_error_i;
      // Zeroization ignores the OTP valid level
      m_zero  = (&zeroize_mask_i) && zeroize_ppd_i;
      if (otp_valid_i) begin
        // Output of the current state
        // A kill shows production locked
        m_lc     = DEVICE_PRODUCTION;
        m_locked = 1'b1;
        if (m_state != TRANS_RESET && m_state != TRANS_IDLE && !m_kill) begin
          case (m_state)
            TRANS_UNPROV_DEBUG: begin
              m_lc     = DEVICE_UNPROVISIONED;
              m_locked = 1'b0;
            end
            TRANS_MANUF_NON_DEBUG: m_lc = DEVICE_MANUFACTURING;
            TRANS_MANUF_DEBUG: begin
              m_lc     = DEVICE_MANUFACTURING;
              m_locked = 1'b0;
            end
            TRANS_PROD_DEBUG: m_locked = 1'b0;
            default: ;
          endcase
        end
        m_next = m_state;
        if (m_state == TRANS_RESET) begin
          m_next = TRANS_IDLE;
        end else if (m_state == TRANS_IDLE) begin
          m_next = m_kill ? TRANS_NON_DEBUG : class_state(int'(m_otp));
        end else if (m_kill) begin
          m_next = TRANS_NON_DEBUG;
        end else if (m_state == TRANS_MANUF_NON_DEBUG && manuf_dbg_en_i) begin
          m_next = TRANS_MANUF_DEBUG;
        end else if (m_state == TRANS_PROD_NON_DEBUG && |(unlock_level_i & dbg_unlock_mask_i)) begin
          m_next = TRANS_PROD_DEBUG;
        end
        m_state = m_next;
        m_otp   = otp_state_i;
        m_dft   = ((lc_dft_en_i == `LC_TX_ON) || |(unlock_level_i & dft_en_mask_i)) && !m_scrap;
        m_hw    = ((lc_hw_debug_en_i == `LC_TX_ON) || |(unlock_level_i & cltap_unlock_mask_i))
                  && !m_scrap;
      end else begin
        m_state  = TRANS_RESET;
        m_otp    = LC_RAW;
        m_lc     = DEVICE_PRODUCTION;
        m_locked = 1'b1;
        m_dft    = 1'b0;
        m_hw     = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_lifecycle(input string name, input device_lifecycle_e exp,
                                 input device_lifecycle_e act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %s actual %s", $time, name, exp.name(), act.name());
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk_i) begin
    check_lifecycle("device_lifecycle_o", m_lc, device_lifecycle_o);
    check_flag("debug_locked_o", m_locked, debug_locked_o);
    check_flag("soc_dft_en_o", m_dft, soc_dft_en_o);
    check_flag("soc_hw_debug_en_o", m_hw, soc_hw_debug_en_o);
    check_flag("zeroize_cmd_o", m_zero, zeroize_cmd_o);
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  // One clock of inputs
  // A negative code picks a random one
  task automatic drive_cycle(input int code, input logic valid, input int kill_pct,
                             input int manuf_pct, input int level_pct);
    logic [31:0] r;
    @(posedge clk_i);
    r = rand_word();
    otp_valid_i         <= valid;
    otp_state_i         <= lc_state_e'((code < 0) ? r[4:0] : code[4:0]);
    lc_prog_req_i       <= roll(50);
    lc_alive_state_i    <= roll(2 * kill_pct) ? LC_SCRAP : LC_DEV;
    state_error_i       <= roll(kill_pct);
    manuf_dbg_en_i      <= roll(manuf_pct);
    lc_dft_en_i         <= roll(50) ? `LC_TX_ON : r[11:8];
    lc_hw_debug_en_i    <= roll(50) ? `LC_TX_ON : r[15:12];
    // Sparse unlock level with a single bit when present
    unlock_level_i      <= roll(level_pct) ? (64'd1 << r[21:16]) : '0;
    dft_en_mask_i       <= {rand_word(), rand_word()};
    dbg_unlock_mask_i   <= {rand_word(), rand_word()};
    cltap_unlock_mask_i <= {rand_word(), rand_word()};
    zeroize_mask_i      <= roll(50) ? '1 : rand_word();
    zeroize_ppd_i       <= roll(60);
  endtask

  task automatic run_phase(input int code, input int cycles, input int kill_pct,
                           input int manuf_pct, input int level_pct, input int valid_pct);
    repeat (2) drive_cycle(code, 1'b0, kill_pct, manuf_pct, level_pct);
    repeat (cycles) drive_cycle(code, roll(valid_pct), kill_pct, manuf_pct, level_pct);
  endtask

  initial begin
    rst_ni              = 1'b0;
    otp_valid_i         = 1'b0;
    otp_state_i         = LC_RAW;
    lc_prog_req_i       = 1'b0;
    lc_alive_state_i    = LC_RAW;
    lc_dft_en_i         = '0;
    lc_hw_debug_en_i    = '0;
    state_error_i       = 1'b0;
    manuf_dbg_en_i      = 1'b0;
    unlock_level_i      = '0;
    dft_en_mask_i       = '0;
    dbg_unlock_mask_i   = '0;
    cltap_unlock_mask_i = '0;
    zeroize_mask_i      = '0;
    zeroize_ppd_i       = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Invalid OTP data with busy inputs
    run_phase(-1, 40, 20, 20, 30, 0);
    // Every code held with no kill and no unlock
    for (int c = 0; c < 32; c++) begin
      run_phase(c, 8, 0, 0, 0, 100);
    end
    // Manufacturing and production unlock
    run_phase(16, 60, 0, 10, 15, 100);
    run_phase(17, 60, 0, 10, 15, 100);
    run_phase(18, 60, 0, 10, 15, 100);
    // Kill paths from a fixed valid code
    repeat (10) run_phase(int'(rand_word() % 21), 20, 5, 5, 10, 100);
    // Mixed traffic with valid drops
    repeat (4) run_phase(-1, 50, 3, 10, 10, 90);

    @(negedge clk_i);
    $display("Finished with no errors");
    $finish;
  end

  // Watchdog
  initial begin
    #((TOTAL_CYC + 100) * 20);
    $display("Error: the simulation ran past its expected length and timed out");
    $display("Finished with errors");
    $fatal(1);
  end

endmodule

//--- all.f
+incdir+rtl
rtl/lcc_trans_pkg.sv
rtl/soc_unlock_policy.sv
rtl/sec_state_fsm.sv
rtl/debug_enable_gate.sv
rtl/lcc_st_trans_top.sv
test/tb_lcc_st_trans.sv
